/* design/pmaPkg.sv */
package pmaPkg;

  // Physical address is PA 14..35, numbered as on the machine.
  localparam int paWidth = 22;
  localparam int baseWidth = 13;   // Page frame, bits 14..26.
  localparam int offsetWidth = 9;  // Page offset, bits 27..35.

  typedef logic [14:13+paWidth] physAddrT;
  typedef logic [14:13+baseWidth] baseT;
  typedef logic [14+baseWidth:13+baseWidth+offsetWidth] offsetT;

  typedef enum logic [2:0] {
    cycEraRead,
    cycPageRefill,
    cycChan,
    cycWriteback,
    cycCca,
    cycEbox
  } cycleTypeT;

  // Highest priority grant first.
  typedef struct packed {
    logic eraGrant;
    logic refillGrant;
    logic chanGrant;
    logic writebackGrant;
    logic ccaGrant;
    logic eboxGrant;
  } grantVecT;

  typedef struct packed {
    logic valid;
    grantVecT grants;
    physAddrT va;
    logic user;   // UBR for page refill.
    logic paged;
    baseT pfn;    // Frame from the page table.
  } pmaReqT;

  typedef struct packed {
    logic valid;
    logic loadUbr;
    logic loadEbr;
    baseT data;
  } baseLoadT;

  typedef struct packed {
    logic valid;
    physAddrT start;
  } ccaLoadT;

  typedef struct packed {
    logic valid;
    cycleTypeT cycle;
    physAddrT va;
    logic user;
    logic paged;
    baseT pfn;
  } decodedT;

  typedef struct packed {
    logic valid;
    cycleTypeT cycle;
    physAddrT pa;
    logic sweepZero;
  } addrT;

  typedef struct packed {
    logic valid;
    cycleTypeT cycle;
    physAddrT pa;
    logic adrPar;
    logic ccaDone;
  } pmaResT;

endpackage

/* design/pmaCycleDecode.sv */
`timescale 1ns/10ps

module pmaCycleDecode (
  input  logic clock,
  input  logic rst,
  input  pmaPkg::pmaReqT req,
  output pmaPkg::decodedT dec
);

  pmaPkg::cycleTypeT cycleNext;
  logic anyGrant;

  assign anyGrant = |req.grants;

  // Fixed priority, ERA read highest and EBOX lowest.
  always_comb begin
    if (req.grants.eraGrant) begin
      cycleNext = pmaPkg::cycEraRead;
    end else if (req.grants.refillGrant) begin
      cycleNext = pmaPkg::cycPageRefill;
    end else if (req.grants.chanGrant) begin
      cycleNext = pmaPkg::cycChan;
    end else if (req.grants.writebackGrant) begin
      cycleNext = pmaPkg::cycWriteback;
    end else if (req.grants.ccaGrant) begin
      cycleNext = pmaPkg::cycCca;
    end else begin
      cycleNext = pmaPkg::cycEbox;
    end
  end

  always_ff @(posedge clock) begin
    if (rst) begin
      dec.valid <= 1'b0;
    end else begin
      dec.valid <= req.valid & anyGrant;  // No grant, no cycle.
    end
    dec.cycle <= cycleNext;
    dec.va <= req.va;
    dec.user <= req.user;
    dec.paged <= req.paged;
    dec.pfn <= req.pfn;
  end

endmodule

/* design/pmaAddrExecute.sv */
`timescale 1ns/10ps

module pmaAddrExecute (
  input  logic clock,
  input  logic rst,
  input  pmaPkg::decodedT dec,
  input  pmaPkg::baseLoadT baseLoad,
  input  pmaPkg::ccaLoadT ccaLoad,
  output pmaPkg::addrT addr
);

  pmaPkg::baseT ubr;
  pmaPkg::baseT ebr;
  pmaPkg::baseT refillBase;
  pmaPkg::physAddrT cca;
  pmaPkg::physAddrT era;
  pmaPkg::physAddrT paNext;
  pmaPkg::offsetT ccaLow;
  logic ccaStep;
  logic eraHold;

  assign refillBase = dec.user ? ubr : ebr;
  assign ccaLow = cca[27:35];
  assign ccaStep = dec.valid && (dec.cycle == pmaPkg::cycCca);
  assign eraHold = !dec.valid || (dec.cycle == pmaPkg::cycEraRead);

  // Physical address source per cycle type.
  always_comb begin
    case (dec.cycle)
      pmaPkg::cycEraRead: begin
        paNext = era;
      end
      pmaPkg::cycPageRefill: begin
        paNext = {refillBase, dec.va[18:26]};  // Table base plus page index.
      end
      pmaPkg::cycChan: begin
        paNext = dec.va;
      end
      pmaPkg::cycWriteback: begin
        paNext = {dec.va[14:33], 2'b00};  // Start of the cache line.
      end
      pmaPkg::cycCca: begin
        paNext = cca;
      end
      default: begin
        if (dec.paged) begin
          paNext = {dec.pfn, dec.va[27:35]};
        end else begin
          paNext = dec.va;
        end
      end
    endcase
  end

  // Page table base registers.
  always_ff @(posedge clock) begin
    if (rst) begin
      ubr <= '0;
      ebr <= '0;
    end else if (baseLoad.valid) begin
      if (baseLoad.loadUbr) begin
        ubr <= baseLoad.data;
      end
      if (baseLoad.loadEbr) begin
        ebr <= baseLoad.data;
      end
    end
  end

  // Sweep counter, an explicit load beats the count.
  always_ff @(posedge clock) begin
    if (rst) begin
      cca <= '0;
    end else if (ccaLoad.valid) begin
      cca <= ccaLoad.start;
    end else if (ccaStep) begin
      cca[27:35] <= ccaLow - 9'd1;  // Wraps past zero.
    end
  end

  always_ff @(posedge clock) begin
    if (rst) begin
      era <= '0;
    end else if (!eraHold) begin
      era <= paNext;
    end
  end

  always_ff @(posedge clock) begin
    if (rst) begin
      addr.valid <= 1'b0;
    end else begin
      addr.valid <= dec.valid;
    end
    addr.cycle <= dec.cycle;
    addr.pa <= paNext;
    addr.sweepZero <= (ccaLow == '0);
  end

endmodule

/* design/pmaAddrResult.sv */
`timescale 1ns/10ps

module pmaAddrResult (
  input  logic clock,
  input  logic rst,
  input  pmaPkg::addrT addr,
  output pmaPkg::pmaResT res
);

  logic adrParNext;
  logic ccaDoneNext;

  // Odd parity over PA 14..35.
  assign adrParNext = ~^addr.pa;

  // Sweep ends when the used count was zero.
  assign ccaDoneNext = (addr.cycle == pmaPkg::cycCca) && addr.sweepZero;

  always_ff @(posedge clock) begin
    if (rst) begin
      res.valid <= 1'b0;
    end else begin
      res.valid <= addr.valid;
    end
    res.cycle <= addr.cycle;
    res.pa <= addr.pa;
    res.adrPar <= adrParNext;
    res.ccaDone <= ccaDoneNext;
  end

endmodule

/* design/pmaTop.sv */
`timescale 1ns/10ps

module pmaTop (
  input  logic clock,
  input  logic rst,
  input  pmaPkg::pmaReqT req,
  input  pmaPkg::baseLoadT baseLoad,
  input  pmaPkg::ccaLoadT ccaLoad,
  output pmaPkg::pmaResT res
);

  pmaPkg::decodedT dec;
  pmaPkg::addrT addr;

  pmaCycleDecode i_pmaCycleDecode (
    .clock(clock),
    .rst(rst),
    .req(req),
    .dec(dec)
  );

  // Holds UBR, EBR, CCA and ERA.
  pmaAddrExecute i_pmaAddrExecute (
    .clock(clock),
    .rst(rst),
    .dec(dec),
    .baseLoad(baseLoad),
    .ccaLoad(ccaLoad),
    .addr(addr)
  );

  pmaAddrResult i_pmaAddrResult (
    .clock(clock),
    .rst(rst),
    .addr(addr),
    .res(res)
  );

endmodule

/* verif/pmaTop_chk.sv */
`timescale 1ns/10ps

module pmaTop_chk (
  input logic clock,
  input logic rst,
  input pmaPkg::pmaReqT req,
  input pmaPkg::baseLoadT baseLoad,
  input pmaPkg::ccaLoadT ccaLoad,
  input pmaPkg::decodedT dec,
  input pmaPkg::addrT addr,
  input pmaPkg::pmaResT res
);

  logic granted;
  logic ccaWon;

  assign granted = req.valid && (|req.grants);  // Only granted requests make a cycle.

  // CCA grant with every higher grant clear.
  assign ccaWon = req.valid && req.grants.ccaGrant &&
                  !(req.grants.eraGrant || req.grants.refillGrant ||
                    req.grants.chanGrant || req.grants.writebackGrant);

  // Three register stages, so exactly three edges.
  latencyThree: assert property (
    @(posedge clock) disable iff (rst)
      res.valid == $past(granted, 3)
  ) else $error("res.valid does not follow a granted request by 3 cycles");

  // All strobes stay quiet from the second reset edge on.
  quietInReset: assert property (
    @(posedge clock)
      (rst && $past(rst)) |-> !(req.valid || baseLoad.valid || ccaLoad.valid ||
                                dec.valid || addr.valid || res.valid)
  ) else $error("valid bit high while reset is held");

  ccaDoneOnCca: assert property (
    @(posedge clock) disable iff (rst)
      (res.valid && res.ccaDone) |-> $past(ccaWon, 3)
  ) else $error("ccaDone set on a result whose request was not a CCA cycle");

endmodule

/* include/pmaRefModel.svh */
`ifndef PMA_REF_MODEL_SVH
`define PMA_REF_MODEL_SVH

pmaPkg::baseT refUbr;
pmaPkg::baseT refEbr;
pmaPkg::physAddrT refCca;
pmaPkg::physAddrT refEra;
pmaPkg::pmaResT expQ[$];

function automatic void refReset();
  refUbr = '0;
  refEbr = '0;
  refCca = '0;
  refEra = '0;
  expQ.delete();
endfunction

// One clock of stimulus, loads before the request.
function automatic void refStep(input pmaPkg::pmaReqT r, input pmaPkg::baseLoadT b,
                                input pmaPkg::ccaLoadT c);
  pmaPkg::pmaResT e;
  if (b.valid && b.loadUbr) refUbr = b.data;
  if (b.valid && b.loadEbr) refEbr = b.data;
  if (c.valid) refCca = c.start;
  if (!r.valid || r.grants == '0) return;
  e = '0;
  e.valid = 1'b1;
  if (r.grants.eraGrant) begin
    e.cycle = pmaPkg::cycEraRead;
    e.pa = refEra;
  end else if (r.grants.refillGrant) begin
    e.cycle = pmaPkg::cycPageRefill;
    e.pa = {(r.user ? refUbr : refEbr), r.va[18:26]};
  end else if (r.grants.chanGrant) begin
    e.cycle = pmaPkg::cycChan;
    e.pa = r.va;
  end else if (r.grants.writebackGrant) begin
    e.cycle = pmaPkg::cycWriteback;
    e.pa = {r.va[14:33], 2'b00};
  end else if (r.grants.ccaGrant) begin
    e.cycle = pmaPkg::cycCca;
    e.pa = refCca;
    e.ccaDone = (refCca[27:35] == '0);
    refCca[27:35] = refCca[27:35] - 9'd1;
  end else begin
    e.cycle = pmaPkg::cycEbox;
    e.pa = r.paged ? {r.pfn, r.va[27:35]} : r.va;
  end
  if (e.cycle != pmaPkg::cycEraRead) refEra = e.pa;
  e.adrPar = ~^e.pa;
  expQ.push_back(e);
endfunction

`endif

/* verif/pmaTb.sv */
`timescale 1ns/10ps

module pmaTb;

  localparam int numCycles = 3000;
  localparam int directedCycles = 16;  // Upper bound for runDirected.
  localparam int drainCycles = 6;
  localparam int resetCycles = 2;

  logic clock;
  logic rst;
  pmaPkg::pmaReqT req;
  pmaPkg::baseLoadT baseLoad;
  pmaPkg::ccaLoadT ccaLoad;
  pmaPkg::pmaResT res;
  integer seed;
  int cycleCount [6];
  int ccaDoneCount;
  int resultCount;

  `include "pmaRefModel.svh"

  pmaTop i_pmaTop (
    .clock(clock),
    .rst(rst),
    .req(req),
    .baseLoad(baseLoad),
    .ccaLoad(ccaLoad),
    .res(res)
  );

  bind pmaTop pmaTop_chk i_pmaTopChk (
    .clock(clock),
    .rst(rst),
    .req(req),
    .baseLoad(baseLoad),
    .ccaLoad(ccaLoad),
    .dec(dec),
    .addr(addr),
    .res(res)
  );

  initial clock = 1'b0;
  always #50 clock = ~clock;

  task automatic abortRun(input string msg);
    $display("%s", msg);
    $display("ERRORS FOUND");
    $fatal(1, "Simulation stopped at first error.");
  endtask

  task automatic checkCycle(input string name, input pmaPkg::cycleTypeT got,
                            input pmaPkg::cycleTypeT exp);
    if (got !== exp) begin
      abortRun($sformatf("FAILED at %0t: %s got %s expected %s",
                         $time, name, got.name(), exp.name()));
    end
  endtask

  task automatic checkAddr(input string name, input pmaPkg::physAddrT got,
                           input pmaPkg::physAddrT exp);
    if (got !== exp) begin
      abortRun($sformatf("FAILED at %0t: %s got %h expected %h", $time, name, got, exp));
    end
  endtask

  task automatic checkFlag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      abortRun($sformatf("FAILED at %0t: %s got %b expected %b", $time, name, got, exp));
    end
  endtask

  // Results are stable at the falling edge.
  task automatic checkResult();
    pmaPkg::pmaResT exp;
    if (res.valid) begin
      if (expQ.size() == 0) begin
        abortRun($sformatf("Result strobe at %0t with no request outstanding", $time));
      end else begin
        exp = expQ.pop_front();
        checkCycle("res.cycle", res.cycle, exp.cycle);
        checkAddr("res.pa", res.pa, exp.pa);
        checkFlag("res.adrPar", res.adrPar, exp.adrPar);
        checkFlag("res.ccaDone", res.ccaDone, exp.ccaDone);
        cycleCount[int'(res.cycle)]++;
        ccaDoneCount += int'(res.ccaDone);
        resultCount++;
      end
    end
  endtask

  // One clock: check, then drive new inputs and step the model.
  task automatic applyCycle(input pmaPkg::pmaReqT r, input pmaPkg::baseLoadT b,
                            input pmaPkg::ccaLoadT c);
    @(negedge clock);
    checkResult();
    req = r;
    baseLoad = b;
    ccaLoad = c;
    refStep(r, b, c);
  endtask

  function automatic pmaPkg::pmaReqT makeReq(input logic [5:0] grants,
                                             input pmaPkg::physAddrT va, input logic user,
                                             input logic paged, input pmaPkg::baseT pfn);
    pmaPkg::pmaReqT r;
    r.valid = 1'b1;
    r.grants = grants;  // ERA grant is the top bit.
    r.va = va;
    r.user = user;
    r.paged = paged;
    r.pfn = pfn;
    return r;
  endfunction

  function automatic pmaPkg::baseLoadT makeBase(input logic loadUbr, input logic loadEbr,
                                                input pmaPkg::baseT data);
    pmaPkg::baseLoadT b;
    b.valid = 1'b1;
    b.loadUbr = loadUbr;
    b.loadEbr = loadEbr;
    b.data = data;
    return b;
  endfunction

  function automatic pmaPkg::ccaLoadT makeCca(input pmaPkg::physAddrT start);
    pmaPkg::ccaLoadT c;
    c.valid = 1'b1;
    c.start = start;
    return c;
  endfunction

  task automatic runDirected();
    applyCycle(makeReq(6'b000001, 22'h2a5f3c, 1'b0, 1'b1, 13'h1abc), '0, '0);  // Paged EBOX.
    applyCycle(makeReq(6'b000001, 22'h15a0c3, 1'b0, 1'b0, 13'h0555), '0, '0);
    applyCycle(makeReq(6'b001000, 22'h3c0f11, 1'b1, 1'b1, 13'h0fff), '0, '0);
    // Refill with a base load on the same edge.
    applyCycle(makeReq(6'b010000, 22'h07c1a5, 1'b1, 1'b0, '0),
               makeBase(1'b1, 1'b0, 13'h0f0f), '0);
    applyCycle(makeReq(6'b010000, 22'h07c1a5, 1'b0, 1'b0, '0),
               makeBase(1'b0, 1'b1, 13'h1234), '0);
    applyCycle(makeReq(6'b000100, 22'h3fffff, 1'b0, 1'b0, '0), '0, '0);  // Writeback.
    applyCycle(makeReq(6'b100000, 22'h000000, 1'b0, 1'b0, '0), '0, '0);
    // Sweep from 2 down through zero and the wrap.
    applyCycle(makeReq(6'b000010, 22'h000000, 1'b0, 1'b0, '0), '0, makeCca(22'h2aa002));
    repeat (3) applyCycle(makeReq(6'b000010, 22'h000000, 1'b0, 1'b0, '0), '0, '0);
    applyCycle(makeReq(6'b111111, 22'h123456, 1'b1, 1'b1, 13'h0aaa), '0, '0);
    applyCycle(makeReq(6'b001011, 22'h0fedcb, 1'b0, 1'b1, 13'h1555), '0, '0);
    applyCycle(makeReq(6'b000000, 22'h111111, 1'b0, 1'b0, '0), '0, '0);  // No grant.
    applyCycle(makeReq(6'b100000, 22'h000000, 1'b0, 1'b0, '0), '0, '0);
  endtask

  task automatic driveRandom();
    logic [31:0] r0;
    logic [31:0] r1;
    logic [31:0] r2;
    logic [31:0] r3;
    pmaPkg::pmaReqT r;
    pmaPkg::baseLoadT b;
    pmaPkg::ccaLoadT c;
    r0 = $random(seed);
    r1 = $random(seed);
    r2 = $random(seed);
    r3 = $random(seed);
    r.valid = (r0[2:0] != 3'd0);
    r.grants = r1[5:0] & r1[11:6];  // Each grant set a quarter of the time.
    r.va = r2[21:0];
    r.user = r0[3];
    r.paged = r0[4];
    r.pfn = r3[12:0];
    b.valid = (r0[8:5] == 4'd0);
    b.loadUbr = r0[9];
    b.loadEbr = r0[10];
    b.data = r3[25:13];
    c.valid = (r0[15:11] == 5'd0);
    c.start = {r1[24:12], 6'd0, r2[24:22]};  // Short sweeps reach zero often.
    applyCycle(r, b, c);
  endtask

  task automatic printSummary();
    pmaPkg::cycleTypeT t;
    $display("%0d results checked, %0d with ccaDone", resultCount, ccaDoneCount);
    for (int i = 0; i < 6; i++) begin
      t = pmaPkg::cycleTypeT'(i);
      $display("  %-14s %0d", t.name(), cycleCount[i]);
    end
  endtask

  initial begin
    #((resetCycles + directedCycles + numCycles + drainCycles + 20) * 100);
    abortRun("Timeout: the run did not finish in the expected number of cycles");
  end

  initial begin
    seed = 32'hd9a2;
    rst = 1'b1;
    req = '0;
    baseLoad = '0;
    ccaLoad = '0;
    resultCount = 0;
    ccaDoneCount = 0;
    foreach (cycleCount[i]) cycleCount[i] = 0;
    refReset();
    repeat (resetCycles) @(posedge clock);
    @(negedge clock);
    rst = 1'b0;
    runDirected();
    repeat (numCycles) driveRandom();
    repeat (drainCycles) applyCycle('0, '0, '0);
    printSummary();
    if (expQ.size() != 0) begin
      abortRun($sformatf("%0d expected results never came out", expQ.size()));
    end else begin
      $display("NO ERRORS");
      $finish;
    end
  end

endmodule

/* pmaSub.f */
+incdir+include
design/pmaPkg.sv
design/pmaCycleDecode.sv
design/pmaAddrExecute.sv
design/pmaAddrResult.sv
design/pmaTop.sv
verif/pmaTop_chk.sv
verif/pmaTb.sv

/* run.sh */
#!/usr/bin/env bash
# Builds pmaTb with Verilator and runs it; the exit status is the verdict.
cd "$(dirname "$0")" &&
  verilator --binary --timing --assert -f pmaSub.f --top-module pmaTb -o pmaSim &&
  ./obj_dir/pmaSim ||
  {
    echo "pmaSub simulation failed"
    exit 1
  }
